/* common/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// first fetch address out of reset
`define CPU_RESET_PC        32'h1c000000
`define CPU_NUM_REGS        32

// instruction word fields
`define CPU_RD_FIELD        4:0
`define CPU_RJ_FIELD        9:5
`define CPU_RK_FIELD        14:10
`define CPU_SI12_FIELD      21:10
`define CPU_SI16_FIELD      25:10
`define CPU_SI20_FIELD      24:5
// high ten bits of si26 sit in the rj and rd slots
`define CPU_OFFS26_HI_FIELD 9:0

`endif

/* common/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] alu_op_t;

    // bit positions inside alu_op_t
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef enum logic [2:0] {
        IF,
        ID,
        EXE,
        MEM,
        WB
    } ctrl_state_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      res_from_mem;
        logic      gr_we;
        logic      mem_we;
        logic      is_beq;
        logic      is_bne;
        logic      is_jirl;
        logic      is_b_or_bl;
        logic      needs_exe;   // false only for b, beq, bne and unknown words
        logic      needs_mem;
        reg_addr_t dest;
        reg_addr_t raddr2;
        word_t     imm;
        word_t     br_offs;
    } decode_t;

endpackage

`default_nettype wire

/* verilog/inst_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module inst_decoder (
    input  cpu_pkg::word_t   inst,
    output cpu_pkg::decode_t dec
);
    import cpu_pkg::*;

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;
    logic        is_3r;
    logic        is_shift;
    logic        inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic        inst_nor, inst_and, inst_or, inst_xor;
    logic        inst_slli_w, inst_srli_w, inst_srai_w, inst_addi_w;
    logic        inst_ld_w, inst_st_w, inst_jirl, inst_b;
    logic        inst_bl, inst_beq, inst_bne, inst_lu12i_w;
    logic        src2_is_4;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];

    assign i12 = inst[`CPU_SI12_FIELD];
    assign i16 = inst[`CPU_SI16_FIELD];
    assign i20 = inst[`CPU_SI20_FIELD];
    assign i26 = {inst[`CPU_OFFS26_HI_FIELD], inst[`CPU_SI16_FIELD]};

    // three-register and shift-by-immediate groups
    assign is_3r    = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign is_shift = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);

    assign inst_add_w   = is_3r && (op_19_15 == 5'h00);
    assign inst_sub_w   = is_3r && (op_19_15 == 5'h02);
    assign inst_slt     = is_3r && (op_19_15 == 5'h04);
    assign inst_sltu    = is_3r && (op_19_15 == 5'h05);
    assign inst_nor     = is_3r && (op_19_15 == 5'h08);
    assign inst_and     = is_3r && (op_19_15 == 5'h09);
    assign inst_or      = is_3r && (op_19_15 == 5'h0a);
    assign inst_xor     = is_3r && (op_19_15 == 5'h0b);
    assign inst_slli_w  = is_shift && (op_19_15 == 5'h01);
    assign inst_srli_w  = is_shift && (op_19_15 == 5'h09);
    assign inst_srai_w  = is_shift && (op_19_15 == 5'h11);
    assign inst_addi_w  = (op_31_26 == 6'h00) && (op_25_22 == 4'ha);
    assign inst_ld_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h2);
    assign inst_st_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h6);
    assign inst_jirl    = (op_31_26 == 6'h13);
    assign inst_b       = (op_31_26 == 6'h14);
    assign inst_bl      = (op_31_26 == 6'h15);
    assign inst_beq     = (op_31_26 == 6'h16);
    assign inst_bne     = (op_31_26 == 6'h17);
    assign inst_lu12i_w = (op_31_26 == 6'h05) && !inst[25];

    // link value pc+4 goes through the adder
    assign src2_is_4 = inst_jirl | inst_bl;

    always_comb begin
        dec.alu_op           = '0;
        dec.alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                             | inst_jirl | inst_bl;
        dec.alu_op[ALU_SUB]  = inst_sub_w;
        dec.alu_op[ALU_SLT]  = inst_slt;
        dec.alu_op[ALU_SLTU] = inst_sltu;
        dec.alu_op[ALU_AND]  = inst_and;
        dec.alu_op[ALU_NOR]  = inst_nor;
        dec.alu_op[ALU_OR]   = inst_or;
        dec.alu_op[ALU_XOR]  = inst_xor;
        dec.alu_op[ALU_SLL]  = inst_slli_w;
        dec.alu_op[ALU_SRL]  = inst_srli_w;
        dec.alu_op[ALU_SRA]  = inst_srai_w;
        dec.alu_op[ALU_LUI]  = inst_lu12i_w;

        dec.src1_is_pc   = inst_jirl | inst_bl;
        dec.src2_is_imm  = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w
                         | inst_ld_w | inst_st_w | inst_lu12i_w | src2_is_4;
        dec.res_from_mem = inst_ld_w;
        dec.gr_we        = inst_add_w | inst_sub_w | inst_slt | inst_sltu
                         | inst_nor | inst_and | inst_or | inst_xor
                         | inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w
                         | inst_lu12i_w | inst_ld_w | inst_jirl | inst_bl;
        dec.mem_we       = inst_st_w;
        dec.is_beq       = inst_beq;
        dec.is_bne       = inst_bne;
        dec.is_jirl      = inst_jirl;
        dec.is_b_or_bl   = inst_b | inst_bl;
        // unknown words fall out here and behave like an untaken branch
        dec.needs_exe    = dec.gr_we | inst_st_w;
        dec.needs_mem    = inst_ld_w | inst_st_w;

        dec.dest   = inst_bl ? 5'd1 : inst[`CPU_RD_FIELD];
        dec.raddr2 = (inst_beq | inst_bne | inst_st_w) ? inst[`CPU_RD_FIELD]
                                                        : inst[`CPU_RK_FIELD];

        if (src2_is_4) begin
            dec.imm = 32'h4;
        end else if (inst_lu12i_w) begin
            dec.imm = {i20, 12'b0};
        end else begin
            dec.imm = {{20{i12[11]}}, i12};
        end

        dec.br_offs = (inst_b | inst_bl) ? {{4{i26[25]}}, i26, 2'b0}
                                         : {{14{i16[15]}}, i16, 2'b0};
    end

endmodule

`default_nettype wire

/* verilog/regfile.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module regfile (
    input  logic               clk,
    input  cpu_pkg::reg_addr_t raddr1,
    input  cpu_pkg::reg_addr_t raddr2,
    output cpu_pkg::word_t     rdata1,
    output cpu_pkg::word_t     rdata2,
    input  logic               we,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata
);
    import cpu_pkg::*;

    word_t rf [`CPU_NUM_REGS];

    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 reads as zero and its storage is never written
    assign rdata1 = (raddr1 == 5'd0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : rf[raddr2];

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  cpu_pkg::alu_op_t alu_op,
    input  cpu_pkg::word_t   alu_src1,
    input  cpu_pkg::word_t   alu_src2,
    output cpu_pkg::word_t   alu_result
);
    import cpu_pkg::*;

    word_t      add_result;
    word_t      sub_result;
    word_t      slt_result;
    word_t      sltu_result;
    word_t      sll_result;
    word_t      srl_result;
    word_t      sra_result;
    logic [4:0] shamt;

    assign shamt = alu_src2[4:0];

    assign add_result  = alu_src1 + alu_src2;
    assign sub_result  = alu_src1 - alu_src2;
    assign slt_result  = {31'b0, $signed(alu_src1) < $signed(alu_src2)};
    assign sltu_result = {31'b0, alu_src1 < alu_src2};
    assign sll_result  = alu_src1 << shamt;
    assign srl_result  = alu_src1 >> shamt;
    assign sra_result  = word_t'($signed(alu_src1) >>> shamt);

    // one-hot and-or mux
    assign alu_result = ({32{alu_op[ALU_ADD]}}  & add_result)
                      | ({32{alu_op[ALU_SUB]}}  & sub_result)
                      | ({32{alu_op[ALU_SLT]}}  & slt_result)
                      | ({32{alu_op[ALU_SLTU]}} & sltu_result)
                      | ({32{alu_op[ALU_AND]}}  & (alu_src1 & alu_src2))
                      | ({32{alu_op[ALU_NOR]}}  & ~(alu_src1 | alu_src2))
                      | ({32{alu_op[ALU_OR]}}   & (alu_src1 | alu_src2))
                      | ({32{alu_op[ALU_XOR]}}  & (alu_src1 ^ alu_src2))
                      | ({32{alu_op[ALU_SLL]}}  & sll_result)
                      | ({32{alu_op[ALU_SRL]}}  & srl_result)
                      | ({32{alu_op[ALU_SRA]}}  & sra_result)
                      | ({32{alu_op[ALU_LUI]}}  & alu_src2);

endmodule

`default_nettype wire

/* verilog/multicycle_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module multicycle_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 needs_exe,
    input  logic                 needs_mem,
    input  logic                 res_from_mem,
    output cpu_pkg::ctrl_state_t state
);
    import cpu_pkg::*;

    ctrl_state_t state_next;
    logic        mem_pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IF;
            mem_pending <= 1'b0;
        end else begin
            state <= state_next;
            // class bits are only valid while the word is decoded
            if (state == ID) begin
                mem_pending <= needs_mem;
            end
        end
    end

    always_comb begin
        state_next = IF;
        case (state)
            IF: begin
                state_next = ID;
            end
            ID: begin
                state_next = needs_exe ? EXE : IF;
            end
            EXE: begin
                state_next = mem_pending ? MEM : WB;
            end
            MEM: begin
                // stores finish here while loads still write back
                state_next = res_from_mem ? WB : IF;
            end
            WB: begin
                state_next = IF;
            end
            default: begin
                state_next = IF;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/mycpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module mycpu_top (
    input  logic               clk,
    input  logic               reset,
    output logic               inst_sram_we,
    output cpu_pkg::word_t     inst_sram_addr,
    output cpu_pkg::word_t     inst_sram_wdata,
    input  cpu_pkg::word_t     inst_sram_rdata,
    output logic               data_sram_we,
    output cpu_pkg::word_t     data_sram_addr,
    output cpu_pkg::word_t     data_sram_wdata,
    input  cpu_pkg::word_t     data_sram_rdata,
    output cpu_pkg::word_t     debug_wb_pc,
    output logic [3:0]         debug_wb_rf_we,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);
    import cpu_pkg::*;

    ctrl_state_t state;
    word_t       pc;
    word_t       inst_q;
    decode_t     dec;
    decode_t     dec_q;
    reg_addr_t   rf_raddr1;
    word_t       rj_value;
    word_t       rkd_value;
    word_t       rkd_q;
    word_t       src1_q;
    word_t       src2_q;
    word_t       alu_result;
    word_t       alu_result_q;
    word_t       load_data_q;
    word_t       final_result;
    logic        rj_eq_rd;
    logic        br_taken;
    word_t       br_target;
    word_t       next_pc;
    word_t       next_pc_q;
    logic        rf_we;
    logic        inst_done;

    inst_decoder u_decoder (
        .inst (inst_q),
        .dec  (dec)
    );

    multicycle_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .needs_exe    (dec.needs_exe),
        .needs_mem    (dec.needs_mem),
        .res_from_mem (dec_q.res_from_mem),
        .state        (state)
    );

    assign rf_raddr1 = inst_q[`CPU_RJ_FIELD];

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (dec.raddr2),
        .rdata1 (rj_value),
        .rdata2 (rkd_value),
        .we     (rf_we),
        .waddr  (dec_q.dest),
        .wdata  (final_result)
    );

    alu u_alu (
        .alu_op     (dec_q.alu_op),
        .alu_src1   (src1_q),
        .alu_src2   (src2_q),
        .alu_result (alu_result)
    );

    // branch resolution during ID
    assign rj_eq_rd  = (rj_value == rkd_value);
    assign br_taken  = (dec.is_beq && rj_eq_rd) || (dec.is_bne && !rj_eq_rd)
                     || dec.is_jirl || dec.is_b_or_bl;
    assign br_target = dec.is_jirl ? (rj_value + dec.br_offs) : (pc + dec.br_offs);
    assign next_pc   = br_taken ? br_target : (pc + 32'd4);

    // last cycle of the current instruction
    assign inst_done = ((state == ID) && !dec.needs_exe)
                     || ((state == MEM) && !dec_q.res_from_mem)
                     || (state == WB);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `CPU_RESET_PC;
        end else if (inst_done) begin
            pc <= (state == ID) ? next_pc : next_pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IF) begin
            inst_q <= inst_sram_rdata;
        end
        if (state == ID) begin
            dec_q     <= dec;
            rkd_q     <= rkd_value;
            src1_q    <= dec.src1_is_pc ? pc : rj_value;
            src2_q    <= dec.src2_is_imm ? dec.imm : rkd_value;
            next_pc_q <= next_pc;
        end
        if (state == EXE) begin
            alu_result_q <= alu_result;
        end
        if (state == MEM) begin
            load_data_q <= data_sram_rdata;
        end
    end

    assign final_result = dec_q.res_from_mem ? load_data_q : alu_result_q;
    assign rf_we        = (state == WB) && dec_q.gr_we;

    assign inst_sram_we    = 1'b0;
    assign inst_sram_addr  = pc;
    assign inst_sram_wdata = '0;

    assign data_sram_we    = (state == MEM) && dec_q.mem_we;
    assign data_sram_addr  = alu_result_q;
    assign data_sram_wdata = rkd_q;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dec_q.dest;
    assign debug_wb_rf_wdata = final_result;

endmodule

`default_nettype wire

/* verif/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic word_t lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
endfunction

function automatic int rand_below(int n);
    word_t r;
    r = lcg_next();
    return int'(r[30:8]) % n;
endfunction

// mostly r3..r15 and now and then r0
function automatic logic [4:0] pick_reg();
    if (rand_below(16) == 0) begin
        return 5'd0;
    end
    return 5'(3 + rand_below(13));
endfunction

function automatic word_t enc_3r(logic [4:0] op, logic [4:0] rd, logic [4:0] rj, logic [4:0] rk);
    return {6'h00, 4'h0, 2'h1, op, rk, rj, rd};
endfunction

function automatic word_t enc_shift(logic [4:0] op, logic [4:0] rd, logic [4:0] rj,
                                   logic [4:0] ui5);
    return {6'h00, 4'h1, 2'h0, op, ui5, rj, rd};
endfunction

function automatic word_t enc_i12(logic [9:0] op, logic [4:0] rd, logic [4:0] rj,
                                 logic [11:0] si12);
    return {op, si12, rj, rd};
endfunction

function automatic word_t enc_i16(logic [5:0] op, logic [4:0] rd, logic [4:0] rj,
                                 logic [15:0] offs);
    return {op, offs, rj, rd};
endfunction

function automatic word_t enc_b26(logic [5:0] op, logic [25:0] offs);
    return {op, offs[15:0], offs[25:16]};
endfunction

function automatic word_t enc_lu12i(logic [4:0] rd, logic [19:0] si20);
    return {7'b0001010, si20, rd};
endfunction

function automatic void gen_program();
    logic [4:0] op3r [8] = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09, 5'h0a, 5'h0b};
    logic [4:0] rd;
    logic [4:0] rj;
    logic [4:0] rk;
    word_t      r;
    int         k;
    int         kind;
    prog[0] = enc_lu12i(5'd2, 20'h1c800);
    // jirl base points at the start of the program
    prog[1] = enc_lu12i(5'd16, 20'h1c000);
    for (int n = 3; n < 16; n++) begin
        r = lcg_next();
        prog[n - 1] = enc_i12(10'h00a, 5'(n), 5'd0, r[11:0]);
    end
    for (int i = 15; i < PROG_WORDS - HALT_WORDS; i++) begin
        rd   = pick_reg();
        rj   = pick_reg();
        rk   = pick_reg();
        r    = lcg_next();
        k    = 1 + rand_below(8);
        kind = rand_below(20);
        case (kind)
            0, 1, 2, 3, 4, 5, 6, 7: prog[i] = enc_3r(op3r[kind], rd, rj, rk);
            8:  prog[i] = enc_shift(5'h01, rd, rj, r[4:0]);
            9:  prog[i] = enc_shift(5'h09, rd, rj, r[4:0]);
            10: prog[i] = enc_shift(5'h11, rd, rj, r[4:0]);
            11: prog[i] = enc_i12(10'h00a, rd, rj, r[11:0]);
            12: prog[i] = enc_lu12i(rd, r[19:0]);
            13: prog[i] = enc_i12(10'h0a2, rd, 5'd2, {1'b0, r[8:0], 2'b00});
            14: prog[i] = enc_i12(10'h0a6, rd, 5'd2, {1'b0, r[8:0], 2'b00});
            15: prog[i] = enc_i16(6'h13, rd, 5'd16, 16'(i + k));
            16: prog[i] = enc_b26(6'h14, 26'(k));
            17: prog[i] = enc_b26(6'h15, 26'(k));
            18: prog[i] = enc_i16(6'h16, rd, rj, 16'(k));
            default: prog[i] = enc_i16(6'h17, rd, rj, 16'(k));
        endcase
    end
    for (int i = PROG_WORDS - HALT_WORDS; i < PROG_WORDS; i++) begin
        prog[i] = enc_b26(6'h14, 26'd0);
    end
endfunction

function automatic word_t read_reg(logic [4:0] n);
    return (n == 5'd0) ? 32'd0 : ref_rf[n];
endfunction

function automatic void ref_step(output logic wr, output word_t wpc, output logic [4:0] wnum,
                                 output word_t wdata, output logic st, output word_t saddr,
                                 output word_t sdata, output int cycles);
    word_t inst;
    word_t a;
    word_t b;
    word_t d;
    word_t simm12;
    word_t offs16;
    word_t npc;
    inst   = prog[ref_pc[9:2]];
    a      = read_reg(inst[9:5]);
    b      = read_reg(inst[14:10]);
    d      = read_reg(inst[4:0]);
    simm12 = {{20{inst[21]}}, inst[21:10]};
    offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    wr     = 1'b1;
    st     = 1'b0;
    wpc    = ref_pc;
    wnum   = inst[4:0];
    wdata  = 32'd0;
    saddr  = 32'd0;
    sdata  = 32'd0;
    cycles = 4;
    npc    = ref_pc + 32'd4;
    if (inst[31:20] == 12'h001) begin
        case (inst[19:15])
            5'h00: wdata = a + b;
            5'h02: wdata = a - b;
            5'h04: wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            5'h05: wdata = (a < b) ? 32'd1 : 32'd0;
            5'h08: wdata = ~(a | b);
            5'h09: wdata = a & b;
            5'h0a: wdata = a | b;
            default: wdata = a ^ b;
        endcase
    end else if (inst[31:20] == 12'h004) begin
        case (inst[19:15])
            5'h01: wdata = a << inst[14:10];
            5'h09: wdata = a >> inst[14:10];
            default: wdata = word_t'($signed(a) >>> inst[14:10]);
        endcase
    end else if (inst[31:22] == 10'h00a) begin
        wdata = a + simm12;
    end else if (inst[31:25] == 7'b0001010) begin
        wdata = {inst[24:5], 12'b0};
    end else if (inst[31:22] == 10'h0a2) begin
        saddr  = a + simm12;
        wdata  = ref_mem[saddr[11:2]];
        saddr  = 32'd0;
        cycles = 5;
    end else if (inst[31:22] == 10'h0a6) begin
        wr    = 1'b0;
        st    = 1'b1;
        saddr = a + simm12;
        sdata = d;
        ref_mem[saddr[11:2]] = d;
    end else begin
        case (inst[31:26])
            6'h13: begin
                wdata = ref_pc + 32'd4;
                npc   = a + offs16;
            end
            6'h15: begin
                wnum  = 5'd1;
                wdata = ref_pc + 32'd4;
                npc   = ref_pc + {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
            end
            6'h14: begin
                wr  = 1'b0;
                npc = ref_pc + {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
            end
            6'h16: begin
                wr = 1'b0;
                if (a == d) npc = ref_pc + offs16;
            end
            6'h17: begin
                wr = 1'b0;
                if (a != d) npc = ref_pc + offs16;
            end
            default: wr = 1'b0;
        endcase
        if (!wr) begin
            cycles = 2;
        end
    end
    if (wr && wnum != 5'd0) begin
        ref_rf[wnum] = wdata;
    end
    ref_pc = npc;
endfunction

`endif

/* verif/tb_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module tb_top;
    import cpu_pkg::*;

    localparam int    PROG_WORDS = 256;
    localparam int    HALT_WORDS = 8;
    localparam word_t DATA_BASE  = 32'h1c800000;
    localparam word_t HALT_PC    = `CPU_RESET_PC + (PROG_WORDS - HALT_WORDS) * 4;

    logic       clk = 1'b0;
    logic       reset;
    logic       inst_sram_we;
    word_t      inst_sram_addr;
    word_t      inst_sram_wdata;
    word_t      inst_sram_rdata;
    logic       data_sram_we;
    word_t      data_sram_addr;
    word_t      data_sram_wdata;
    word_t      data_sram_rdata;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_we;
    logic [4:0] debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    word_t      prog [PROG_WORDS];
    word_t      data_mem [1024];
    word_t      ref_mem [1024];
    word_t      ref_rf [32];
    word_t      ref_pc;
    word_t      rng_state;

    int         exp_wb_cyc [$];
    word_t      exp_wb_pc [$];
    logic [4:0] exp_wb_num [$];
    word_t      exp_wb_data [$];
    int         exp_st_cyc [$];
    word_t      exp_st_addr [$];
    word_t      exp_st_data [$];

    int         cyc;
    int         errors;
    int         trace_count;
    int         ref_trace_count;
    int         ref_cycles;
    int         wait_cycles;

    `include "tb_ref_model.svh"

    mycpu_top DUT (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_we      (inst_sram_we),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #20 clk = ~clk;

    // both SRAMs read combinationally
    assign inst_sram_rdata = prog[inst_sram_addr[9:2]];
    assign data_sram_rdata = data_mem[data_sram_addr[11:2]];

    always @(posedge clk) begin
        if (data_sram_we) begin
            data_mem[data_sram_addr[11:2]] <= data_sram_wdata;
        end
    end

    function automatic word_t fill_word(word_t addr);
        return (addr * 32'h9e3779b1) ^ 32'h3c6ef372;
    endfunction

    function automatic void build_expected();
        logic       wr;
        logic       st;
        word_t      wpc;
        word_t      wdata;
        word_t      saddr;
        word_t      sdata;
        logic [4:0] wnum;
        int         cycles;
        int         start;
        int         steps;
        start = 0;
        steps = 0;
        ref_trace_count = 0;
        while (ref_pc < HALT_PC && steps < 5000) begin
            ref_step(wr, wpc, wnum, wdata, st, saddr, sdata, cycles);
            // the write or the store lands in the last cycle of the instruction
            if (wr) begin
                exp_wb_cyc.push_back(start + cycles - 1);
                exp_wb_pc.push_back(wpc);
                exp_wb_num.push_back(wnum);
                exp_wb_data.push_back(wdata);
                ref_trace_count++;
            end
            if (st) begin
                exp_st_cyc.push_back(start + cycles - 1);
                exp_st_addr.push_back(saddr);
                exp_st_data.push_back(sdata);
            end
            start += cycles;
            steps++;
        end
        ref_cycles = start;
    endfunction

    task automatic value_error(string name, word_t got, word_t exp);
        $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic pop_trace();
        void'(exp_wb_cyc.pop_front());
        void'(exp_wb_pc.pop_front());
        void'(exp_wb_num.pop_front());
        void'(exp_wb_data.pop_front());
    endtask

    task automatic pop_store();
        void'(exp_st_cyc.pop_front());
        void'(exp_st_addr.pop_front());
        void'(exp_st_data.pop_front());
    endtask

    task automatic check_idle_outputs();
        if (data_sram_we !== 1'b0) value_error("data_sram_we", {31'b0, data_sram_we}, 32'd0);
        if (debug_wb_rf_we !== 4'h0) value_error("debug_wb_rf_we", {28'b0, debug_wb_rf_we}, 32'd0);
        if (inst_sram_addr !== `CPU_RESET_PC) value_error("inst_sram_addr", inst_sram_addr,
                                                          `CPU_RESET_PC);
    endtask

    // outputs are sampled on the falling edge where they have settled
    always @(negedge clk) begin
        // the instruction port is tied off and never writes
        if (inst_sram_we !== 1'b0) value_error("inst_sram_we", {31'b0, inst_sram_we}, 32'd0);
        if (inst_sram_wdata !== 32'd0) value_error("inst_sram_wdata", inst_sram_wdata, 32'd0);
        if (reset) begin
            check_idle_outputs();
        end else begin
            if (cyc == 0) check_idle_outputs();
            if (debug_wb_rf_we !== 4'h0) begin
                trace_count++;
                if (debug_wb_rf_we !== 4'hf) value_error("debug_wb_rf_we",
                                                         {28'b0, debug_wb_rf_we}, 32'hf);
                if (exp_wb_cyc.size() == 0) begin
                    $display("register write at pc %h after the last expected one", debug_wb_pc);
                    errors++;
                end else begin
                    if (cyc != exp_wb_cyc[0]) value_error("trace cycle", cyc, exp_wb_cyc[0]);
                    if (debug_wb_pc !== exp_wb_pc[0]) value_error("debug_wb_pc", debug_wb_pc,
                                                                  exp_wb_pc[0]);
                    if (debug_wb_rf_wnum !== exp_wb_num[0]) value_error("debug_wb_rf_wnum",
                        {27'b0, debug_wb_rf_wnum}, {27'b0, exp_wb_num[0]});
                    if (debug_wb_rf_wdata !== exp_wb_data[0]) value_error("debug_wb_rf_wdata",
                        debug_wb_rf_wdata, exp_wb_data[0]);
                    pop_trace();
                end
            end else if (exp_wb_cyc.size() != 0 && exp_wb_cyc[0] <= cyc) begin
                $display("no register write seen for pc %h at cycle %0d", exp_wb_pc[0], cyc);
                errors++;
                pop_trace();
            end
            if (data_sram_we === 1'b1) begin
                if (exp_st_cyc.size() == 0) begin
                    $display("store to %h after the last expected one", data_sram_addr);
                    errors++;
                end else begin
                    if (cyc != exp_st_cyc[0]) value_error("store cycle", cyc, exp_st_cyc[0]);
                    if (data_sram_addr !== exp_st_addr[0]) value_error("data_sram_addr",
                        data_sram_addr, exp_st_addr[0]);
                    if (data_sram_wdata !== exp_st_data[0]) value_error("data_sram_wdata",
                        data_sram_wdata, exp_st_data[0]);
                    pop_store();
                end
            end else if (exp_st_cyc.size() != 0 && exp_st_cyc[0] <= cyc) begin
                $display("no store seen to %h at cycle %0d", exp_st_addr[0], cyc);
                errors++;
                pop_store();
            end
            cyc++;
        end
    end

    initial begin
        reset       = 1'b1;
        errors      = 0;
        cyc         = 0;
        trace_count = 0;
        wait_cycles = 0;
        rng_state   = 32'h590f;
        for (int i = 0; i < 1024; i++) begin
            data_mem[i] <= fill_word(DATA_BASE + i * 4);
            ref_mem[i]  = fill_word(DATA_BASE + i * 4);
        end
        for (int i = 0; i < 32; i++) begin
            ref_rf[i] = 32'd0;
        end
        ref_pc = `CPU_RESET_PC;
        gen_program();
        build_expected();

        repeat (5) @(posedge clk);
        #1 reset = 1'b0;

        while (!(inst_sram_addr >= HALT_PC && exp_wb_cyc.size() == 0 && exp_st_cyc.size() == 0)
               && wait_cycles < ref_cycles + 100) begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end
        if (inst_sram_addr < HALT_PC) begin
            $display("the core did not reach the halt loop before the timeout");
            errors++;
        end
        if (exp_wb_cyc.size() != 0 || exp_st_cyc.size() != 0) begin
            $display("%0d register writes and %0d stores never appeared",
                     exp_wb_cyc.size(), exp_st_cyc.size());
            errors++;
        end
        if (trace_count != ref_trace_count) begin
            $display("saw %0d register writes, expected %0d", trace_count, ref_trace_count);
            errors++;
        end

        $display("errors: %0d, register writes checked: %0d", errors, trace_count);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+common
+incdir+verif
common/cpu_pkg.sv
verilog/inst_decoder.sv
verilog/regfile.sv
verilog/alu.sv
verilog/multicycle_ctrl.sv
verilog/mycpu_top.sv
verif/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build tb_top with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps -f project.f --top-module tb_top \
    -Mdir obj_dir -o tb_top_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/tb_top_sim > "$LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status, see $LOG"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi
echo "simulation passed"
exit 0
